//--- alloc_input.txt
// Columns: request bits (bit 0 Local to bit 4 South), then the Local North East West South flits.
// Each flit word holds the id in its top hex digit and the packet length in the low three.
0000 0000 0000 0000 0000 0000
0007 1002 1001 1000 0000 0000
0007 2000 2000 2000 0000 0000
0007 2000 2000 2000 0000 0000
0007 2000 2000 2000 0000 0000
0007 2000 2000 2000 0000 0000
0007 2000 2000 2000 0000 0000
0007 3000 3000 3000 0000 0000
0002 0000 1005 0000 0000 0000
0002 0000 2000 0000 0000 0000
0000 0000 3000 0000 0000 0000
001F 1000 1000 1000 1000 1000
001F 2000 2000 2000 2000 2000
001F 2000 2000 2000 2000 2000
001F 2000 2000 2000 2000 2000
001F 2000 2000 2000 2000 2000
001F 2000 2000 2000 2000 2000
001F 3000 3000 3000 3000 3000
0004 0000 0000 1003 0000 0000
0004 0000 0000 2000 0000 0000
0004 0000 0000 2000 0000 0000
0004 0000 0000 2000 0000 0000
0004 0000 0000 3000 0000 0000
0000 0000 0000 0000 0000 0000

//--- files.f
flitPkg.sv
allocPkg.sv
portLane.sv
switchArbiter.sv
outputStage.sv
outputPortAlloc.sv
tbChecker.sv
tbOutputPortAlloc.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run from the project root and judge the run by its output.
verilator --binary -f files.f --top-module tbOutputPortAlloc -o simTb || exit 1
out=$(./obj_dir/simTb)
echo "$out"
echo "$out" | grep -qx "ALL CHECKS PASSED" && echo "Run passed" || { echo "Run failed"; exit 1; }

//--- tbOutputPortAlloc.sv
`timescale 1ns/1ps
`default_nettype none

module tbOutputPortAlloc;

  localparam int numPorts       = allocPkg::defaultNumPorts;
  localparam int numVectors     = 24; // Lines of data in alloc_input.txt.
  localparam int wordsPerVector = numPorts + 1;
  localparam int resetCycles    = 5;
  localparam int drainCycles    = 4;
  localparam int cycleLimit     = numVectors + 20;

  logic                         clk;
  logic                         rst;
  flitPkg::flitT [numPorts-1:0] inFlit;
  logic [numPorts-1:0]          inReq;
  flitPkg::flitT                outFlit;
  logic                         outValid;
  logic [numPorts:0]            grant;
  int                           mismatchCount;
  logic [numPorts-1:0]          lanesVisited;

  logic [15:0] vecMem [0:numVectors*wordsPerVector-1];
  logic [31:0] rngState = 32'h47d2;
  int          cycleCount;

  outputPortAlloc #(
    .numPorts (numPorts)
  ) i_dut (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inReq    (inReq),
    .outFlit  (outFlit),
    .outValid (outValid),
    .grant    (grant)
  );

  tbChecker #(
    .numPorts (numPorts)
  ) i_chk (
    .clk           (clk),
    .rst           (rst),
    .inFlit        (inFlit),
    .inReq         (inReq),
    .grant         (grant),
    .outFlit       (outFlit),
    .outValid      (outValid),
    .mismatchCount (mismatchCount),
    .lanesVisited  (lanesVisited)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcgStep(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic driveVector(input int v);
    logic [15:0] portWord;

    inReq = vecMem[v*wordsPerVector][numPorts-1:0];
    for (int p = 0; p < numPorts; p++)
    begin
      portWord          = vecMem[v*wordsPerVector+1+p];
      rngState          = lcgStep(rngState);
      inFlit[p].id      = portWord[12 +: flitPkg::idWidth]; // Top hex digit is the id.
      inFlit[p].length  = portWord[flitPkg::lengthWidth-1:0];
      inFlit[p].payload = rngState[31:16];
    end
  endtask

  task automatic clearInputs();
    inReq  = '0;
    inFlit = '0;
  endtask

  initial
  begin : stimulus
    int otherErrs;

    otherErrs = 0;
    rst       = 1'b1;
    clearInputs();
    $readmemh("alloc_input.txt", vecMem);
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int v = 0; v < numVectors; v++)
    begin
      driveVector(v);
      @(negedge clk);
    end
    clearInputs();
    repeat (drainCycles) @(negedge clk); // Lets the last flits leave both stages.
    @(posedge clk);
    for (int p = 0; p < numPorts; p++)
    begin
      if (!lanesVisited[p])
      begin
        $display("Lane %0d was never granted the link during the run.", p);
        otherErrs++;
      end
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherErrs);
    if ((mismatchCount == 0) && (otherErrs == 0))
    begin
      $display("ALL CHECKS PASSED");
    end
    else
    begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial
  begin : watchdog
    cycleCount = 0;
    while (cycleCount < cycleLimit)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the run did not end within %0d clock cycles.", cycleLimit);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tbChecker.sv
`timescale 1ns/1ps
`default_nettype none

module tbChecker #(
  parameter int numPorts = allocPkg::defaultNumPorts
) (
  input  logic                         clk,
  input  logic                         rst,
  input  flitPkg::flitT [numPorts-1:0] inFlit,
  input  logic [numPorts-1:0]          inReq,
  input  logic [numPorts:0]            grant,
  input  flitPkg::flitT                outFlit,
  input  logic                         outValid,
  output int                           mismatchCount,
  output logic [numPorts-1:0]          lanesVisited
);

  flitPkg::flitT                   mLaneFlit [numPorts];
  logic                            mReq      [numPorts];
  logic [flitPkg::lengthWidth-1:0] mHoldLen  [numPorts];
  logic [flitPkg::lengthWidth-1:0] mCount    [numPorts];
  int                              mHolder   = -1; // Lane that owns the link or -1 while idle.
  flitPkg::flitT                   mOutFlit;
  logic                            mOutValid = 1'b0;
  logic                            mOutKnown = 1'b0; // Set once a flit has reached the link.
  logic                            modelLive = 1'b0;
  int                              errs      = 0;
  logic [numPorts-1:0]             visited   = '0;

  assign mismatchCount = errs;
  assign lanesVisited  = visited;

  ////////////////////////////////////////
  // Reference model, one step per edge
  ////////////////////////////////////////

  always @(posedge clk)
  begin : model
    int   newHolder;
    logic keep;

    newHolder = -1;
    keep      = 1'b0;
    if (rst)
    begin
      mHolder   = -1;
      mOutValid = 1'b0;
      for (int p = 0; p < numPorts; p++)
      begin
        mReq[p]      = 1'b0;
        mHoldLen[p]  = '0;
        mCount[p]    = '0;
        mLaneFlit[p] = inFlit[p]; // The flit register itself has no reset.
      end
    end
    else
    begin
      // Grant rule on the registered requests.
      if (mHolder < 0)
      begin
        for (int p = numPorts - 1; p >= 0; p--)
        begin
          if (mReq[p])
          begin
            newHolder = p; // Last hit is the lowest-numbered requester.
          end
        end
      end
      else if (mReq[mHolder] && (mCount[mHolder] != mHoldLen[mHolder]))
      begin
        newHolder = mHolder;
        keep      = 1'b1;
      end
      else
      begin
        for (int off = numPorts - 1; off >= 1; off--)
        begin
          if (mReq[(mHolder + off) % numPorts])
          begin
            newHolder = (mHolder + off) % numPorts; // Nearest one after the holder wins.
          end
        end
      end

      // Link register follows the current grant.
      if (mHolder >= 0)
      begin
        mOutFlit  = mLaneFlit[mHolder];
        mOutKnown = 1'b1;
      end
      mOutValid = (mHolder >= 0);

      for (int p = 0; p < numPorts; p++)
      begin
        if (mLaneFlit[p].id == flitPkg::idHead)
        begin
          mHoldLen[p] = mLaneFlit[p].length;
        end
        if (keep && (p == mHolder))
        begin
          mCount[p] = mCount[p] + 1'b1;
        end
        else
        begin
          mCount[p] = '0;
        end
        mLaneFlit[p] = inFlit[p];
        mReq[p]      = inReq[p];
      end
      mHolder = newHolder;
    end
    modelLive = 1'b1;
  end

  ////////////////////////////////////////
  // Compare on the falling edge
  ////////////////////////////////////////

  always @(negedge clk)
  begin : compare
    logic [numPorts:0] expGrant;

    if (modelLive)
    begin
      expGrant = '0;
      if (mHolder < 0)
      begin
        expGrant[0] = 1'b1;
      end
      else
      begin
        expGrant[mHolder+1] = 1'b1;
      end
      if (grant !== expGrant)
      begin
        $display("Mismatch at %0t: grant expected %b, got %b", $time, expGrant, grant);
        errs++;
      end
      if (outValid !== mOutValid)
      begin
        $display("Mismatch at %0t: outValid expected %b, got %b", $time, mOutValid, outValid);
        errs++;
      end
      if (mOutKnown && (outFlit !== mOutFlit))
      begin
        $display("Mismatch at %0t: outFlit expected %h, got %h", $time, mOutFlit, outFlit);
        errs++;
      end
      for (int p = 0; p < numPorts; p++)
      begin
        if (grant[p+1] === 1'b1)
        begin
          visited[p] = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- outputPortAlloc.sv
`timescale 1ns/1ps
`default_nettype none

module outputPortAlloc #(
  parameter int numPorts = allocPkg::defaultNumPorts
) (
  input  logic                         clk,
  input  logic                         rst,
  input  flitPkg::flitT [numPorts-1:0] inFlit,
  input  logic [numPorts-1:0]          inReq,
  output flitPkg::flitT                outFlit,
  output logic                         outValid,
  output logic [numPorts:0]            grant
);

  flitPkg::flitT [numPorts-1:0]        laneFlit;
  allocPkg::laneStatusT [numPorts-1:0] laneStatus;
  logic [numPorts-1:0]                 runTimer;

  ////////////////////////////////////////
  // Input lanes
  ////////////////////////////////////////

  genvar lane;
  generate
    for (lane = 0; lane < numPorts; lane++)
    begin : gLane
      portLane uLane (
        .clk      (clk),
        .rst      (rst),
        .flitIn   (inFlit[lane]),
        .reqIn    (inReq[lane]),
        .runTimer (runTimer[lane]),
        .laneFlit (laneFlit[lane]),
        .status   (laneStatus[lane])
      );
    end
  endgenerate

  ////////////////////////////////////////
  // Arbiter and link register
  ////////////////////////////////////////

  switchArbiter #(
    .numPorts (numPorts)
  ) uArbiter (
    .clk      (clk),
    .rst      (rst),
    .status   (laneStatus),
    .runTimer (runTimer),
    .grant    (grant)
  );

  outputStage #(
    .numPorts (numPorts)
  ) uOutput (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .laneFlit (laneFlit),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

`default_nettype wire

//--- outputStage.sv
`timescale 1ns/1ps
`default_nettype none

module outputStage #(
  parameter int numPorts = allocPkg::defaultNumPorts
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [numPorts:0]            grant,
  input  flitPkg::flitT [numPorts-1:0] laneFlit,
  output flitPkg::flitT                outFlit,
  output logic                         outValid
);

  flitPkg::flitT selFlit;
  logic          anyGrant;

  assign anyGrant = |grant[numPorts:1];

  always_comb
  begin
    selFlit = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      if (grant[p+1])
      begin
        selFlit = laneFlit[p]; // Grant is one-hot so at most one lane matches.
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (anyGrant)
    begin
      outFlit <= selFlit; // Link keeps the last flit while idle.
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= anyGrant;
    end
  end

endmodule

`default_nettype wire

//--- switchArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module switchArbiter #(
  parameter int numPorts = allocPkg::defaultNumPorts
) (
  input  logic                                clk,
  input  logic                                rst,
  input  allocPkg::laneStatusT [numPorts-1:0] status,
  output logic [numPorts-1:0]                 runTimer,
  output logic [numPorts:0]                   grant
);

  logic [numPorts:0]   grantQ;    // Bit 0 is idle, bit p+1 is lane p.
  logic [numPorts:0]   grantNext;
  logic [numPorts-1:0] reqVec;
  logic [numPorts-1:0] expired;

  always_comb
  begin
    for (int p = 0; p < numPorts; p++)
    begin
      reqVec[p]  = status[p].req;
      expired[p] = status[p].timesUp;
    end
  end

  ////////////////////////////////////////
  // Next grant
  ////////////////////////////////////////

  always_comb
  begin : nextGrant
    int   holder;
    int   idx;
    logic found;

    grantNext    = '0;
    grantNext[0] = 1'b1; // Idle unless a rule below picks a lane.
    runTimer     = '0;
    holder       = 0;
    idx          = 0;
    found        = 1'b0;

    for (int p = 0; p < numPorts; p++)
    begin
      if (grantQ[p+1])
      begin
        holder = p;
      end
    end

    if (grantQ[0])
    begin
      // From idle the lowest-numbered requester wins.
      for (int p = 0; p < numPorts; p++)
      begin
        if (!found && reqVec[p])
        begin
          grantNext      = '0;
          grantNext[p+1] = 1'b1;
          found          = 1'b1;
        end
      end
    end
    else if ($onehot(grantQ))
    begin
      if (reqVec[holder] && !expired[holder])
      begin
        runTimer[holder] = 1'b1; // Holder keeps the link and its timer runs.
        grantNext        = grantQ;
      end
      else
      begin
        // Search the other lanes in circular order after the holder.
        for (int off = 1; off < numPorts; off++)
        begin
          idx = holder + off;
          if (idx >= numPorts)
          begin
            idx = idx - numPorts;
          end
          if (!found && reqVec[idx])
          begin
            grantNext        = '0;
            grantNext[idx+1] = 1'b1;
            found            = 1'b1;
          end
        end
      end
    end
    // A state that is not one-hot falls back to idle.
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grantQ <= {{numPorts{1'b0}}, 1'b1};
    end
    else
    begin
      grantQ <= grantNext;
    end
  end

  assign grant = grantQ;

endmodule

`default_nettype wire

//--- portLane.sv
`timescale 1ns/1ps
`default_nettype none

module portLane (
  input  logic                clk,
  input  logic                rst,
  input  flitPkg::flitT       flitIn,
  input  logic                reqIn,
  input  logic                runTimer,
  output flitPkg::flitT       laneFlit,
  output allocPkg::laneStatusT status
);

  logic                            reqQ;
  logic [flitPkg::lengthWidth-1:0] holdLength;
  logic [flitPkg::lengthWidth-1:0] count;

  ////////////////////////////////////////
  // Input register
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    laneFlit <= flitIn;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      reqQ <= 1'b0;
    end
    else
    begin
      reqQ <= reqIn;
    end
  end

  ////////////////////////////////////////
  // Hold timer
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      holdLength <= '0;
      count      <= '0;
    end
    else
    begin
      if (laneFlit.id == flitPkg::idHead)
      begin
        holdLength <= laneFlit.length; // Body and tail flits leave it alone.
      end
      if (runTimer)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0; // Count restarts whenever the lane is not holding.
      end
    end
  end

  assign status.req     = reqQ;
  assign status.timesUp = (count == holdLength);

endmodule

`default_nettype wire

//--- allocPkg.sv
`default_nettype none

package allocPkg;

  localparam int defaultNumPorts = 5;

  // Lane indices, which are also the idle-state priority order.
  localparam int portLocal = 0;
  localparam int portNorth = 1;
  localparam int portEast  = 2;
  localparam int portWest  = 3;
  localparam int portSouth = 4;

  // What a lane reports to the arbiter every cycle.
  typedef struct packed {
    logic req;     // Registered request level.
    logic timesUp; // Hold count has reached the latched length.
  } laneStatusT;

endpackage

`default_nettype wire

//--- flitPkg.sv
`default_nettype none

package flitPkg;

  ////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////

  localparam int idWidth      = 3;
  localparam int lengthWidth  = 12; // Also the width of the lane hold timer.
  localparam int payloadWidth = 16;

  ////////////////////////////////////////
  // Flit id codes
  ////////////////////////////////////////

  localparam logic [idWidth-1:0] idHead = 3'd1; // Carries the packet length.
  localparam logic [idWidth-1:0] idBody = 3'd2;
  localparam logic [idWidth-1:0] idTail = 3'd3;

  // One flit on a lane or on the output link, 31 bits.
  typedef struct packed {
    logic [idWidth-1:0]      id;
    logic [lengthWidth-1:0]  length;
    logic [payloadWidth-1:0] payload;
  } flitT;

endpackage

`default_nettype wire
